// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cache
FILELIST ?= cache_sys.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== cache/cache.sv ====
module cache import cache_pkg::*; (
	input logic clk,
	input logic reset,

	// pipeline side, request held until cache_hit
	input logic pipe_mem_read, // read request
	input logic [addr_width-1:0] pipe_read_addr, // pc for i-cache, load address for d-cache
	input logic pipe_mem_write, // write request, never with pipe_mem_read
	input logic [addr_width-1:0] pipe_write_addr, // store address
	input logic [addr_width-1:0] pipe_write_data, // store data, also sent to memory

	// memory answers
	input logic mem_data_valid, // one cycle per requested word
	input logic [addr_width-1:0] mem_read_data, // fill word

	// memory control
	output logic cache_mem_read, // fill read, held until mem_data_valid
	output logic cache_mem_write, // write-through, one word per edge
	output logic [addr_width-1:0] cache_mem_addr, // fill, write or read address

	// pipeline results
	output logic [addr_width-1:0] cache_data_out, // word at the working address
	output logic cache_hit, // request found in the cache
	output logic cache_miss, // request missed, starts a fill
	output logic cache_finish, // fill done, tag being written
	output logic cache_busy // fill in progress
);

	logic pipe_req; // any request from the pipeline
	logic [addr_width-1:0] addr; // working address
	logic [tag_width-1:0] tag;
	logic [index_width-1:0] block_index;
	logic [word_sel_width-1:0] block_word; // word for the data array

	logic meta_valid;
	logic [tag_width-1:0] meta_tag;

	logic write_data_array; // fill word strobe
	logic write_tag_array; // fill end strobe
	logic [word_sel_width-1:0] fill_word;
	logic [addr_width-1:0] fill_base_addr;
	logic [addr_width-1:0] fill_read_addr; // address of the pending fill read

	logic data_write; // data array write enable
	logic [addr_width-1:0] data_in; // data array write data

	assign pipe_req = pipe_mem_read | pipe_mem_write;

	// during a fill the arrays follow the block being fetched
	assign addr = cache_busy ? fill_base_addr :
		pipe_mem_write ? pipe_write_addr : pipe_read_addr;

	assign tag = addr[addr_width-1 -: tag_width];
	assign block_index = addr[offset_width +: index_width];
	assign block_word = write_data_array ? fill_word : addr[offset_width-1:1]; // bit 0 ignored

	// hit and miss
	assign cache_hit = meta_valid & (meta_tag == tag) & pipe_req; // tag never matches mid-fill
	assign cache_miss = ~cache_hit & pipe_req & ~cache_busy; // one cycle per missing request
	assign cache_finish = write_tag_array;

	cache_fill_fsm u_fill (
		.clk(clk),
		.reset(reset),
		.miss(cache_miss),
		.mem_data_valid(mem_data_valid),
		.miss_addr(addr),
		.mem_read(cache_mem_read),
		.mem_read_addr(fill_read_addr),
		.write_data_array(write_data_array),
		.fill_word(fill_word),
		.fill_base_addr(fill_base_addr),
		.write_tag_array(write_tag_array),
		.busy(cache_busy)
	);

	cache_meta_array u_meta (
		.clk(clk),
		.reset(reset),
		.index(block_index),
		.tag_in(tag), // base address tag during the fill
		.write(write_tag_array),
		.valid(meta_valid),
		.tag_out(meta_tag)
	);

	// fill data from memory, otherwise pipeline store data on a write hit
	assign data_write = write_data_array | (cache_hit & pipe_mem_write);
	assign data_in = write_data_array ? mem_read_data : pipe_write_data;

	cache_data_array u_data (
		.clk(clk),
		.index(block_index),
		.word(block_word),
		.write(data_write),
		.data_in(data_in),
		.data_out(cache_data_out)
	);

	// write-through, held off while a fill owns the memory port
	assign cache_mem_write = pipe_mem_write & ~cache_busy;

	assign cache_mem_addr = cache_mem_read ? fill_read_addr :
		pipe_mem_write ? pipe_write_addr : pipe_read_addr;

endmodule

// ==== cache/cache_data_array.sv ====
module cache_data_array import cache_pkg::*; (
	input logic clk,

	input logic [index_width-1:0] index, // block entry
	input logic [word_sel_width-1:0] word, // word inside the block
	input logic write, // fill word or write hit
	input logic [addr_width-1:0] data_in, // word to store

	output logic [addr_width-1:0] data_out // word at index and word
);

	localparam int data_addr_width = index_width + word_sel_width; // 10 bits, 1024 words

	// flat word store, block major
	logic [addr_width-1:0] words [num_blocks*words_per_block];
	logic [data_addr_width-1:0] word_addr; // {index, word}

	assign word_addr = {index, word};

	// one word per edge
	always_ff @(posedge clk) begin
		if (write)
			words[word_addr] <= data_in;
	end

	// read in the request cycle
	assign data_out = words[word_addr];

endmodule

// ==== cache/cache_fill_fsm.sv ====
module cache_fill_fsm import cache_pkg::*; (
	input logic clk,
	input logic reset,

	// miss request from the hit logic
	input logic miss, // first cycle of a missing request while idle
	input logic mem_data_valid, // single-cycle strobe from memory
	input logic [addr_width-1:0] miss_addr, // address of the missing access

	// memory read side
	output logic mem_read, // held until mem_data_valid
	output logic [addr_width-1:0] mem_read_addr, // base plus two times word

	// array control
	output logic write_data_array, // store mem_read_data at fill_word
	output logic [word_sel_width-1:0] fill_word, // word being fetched
	output logic [addr_width-1:0] fill_base_addr, // block base with the offset cleared
	output logic write_tag_array, // set valid and tag for the block
	output logic busy // fill in progress
);

	logic [1:0] state; // fill state
	logic [1:0] state_next;
	logic [word_sel_width-1:0] word_cnt; // next word to request
	logic [addr_width-1:0] base_addr; // latched block base address
	logic last_word; // current word is the final one of the block

	assign last_word = (word_cnt == last_fill_word);

	// next state
	always_comb begin
		state_next = state;
		case (state)
			fsm_idle: begin
				if (miss)
					state_next = fsm_fetch; // start the fill next cycle
			end
			fsm_fetch: begin
				if (mem_data_valid && last_word)
					state_next = fsm_finish; // eighth word arrived
			end
			fsm_finish: begin
				state_next = fsm_idle; // tag written this cycle
			end
			default: begin
				state_next = fsm_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= fsm_idle;
		else
			state <= state_next;
	end

	// word counter restarts for each miss
	always_ff @(posedge clk) begin
		if (reset)
			word_cnt <= '0;
		else if (state == fsm_idle)
			word_cnt <= '0;
		else if (state == fsm_fetch && mem_data_valid)
			word_cnt <= word_cnt + 1'b1; // wraps to 0 after the last word
	end

	// block base latched on the miss
	always_ff @(posedge clk) begin
		if (state == fsm_idle && miss)
			base_addr <= {miss_addr[addr_width-1:offset_width], {offset_width{1'b0}}};
	end

	assign busy = (state != fsm_idle);
	assign mem_read = (state == fsm_fetch); // one read pending per word
	assign mem_read_addr = {base_addr[addr_width-1:offset_width], word_cnt, 1'b0};
	assign write_data_array = (state == fsm_fetch) & mem_data_valid; // same cycle as data
	assign fill_word = word_cnt;
	assign fill_base_addr = base_addr;
	assign write_tag_array = (state == fsm_finish); // one cycle pulse

endmodule

// ==== cache/cache_meta_array.sv ====
module cache_meta_array import cache_pkg::*; (
	input logic clk,
	input logic reset,

	input logic [index_width-1:0] index, // block entry
	input logic [tag_width-1:0] tag_in, // tag of the block being filled
	input logic write, // end of fill, mark entry valid

	output logic valid, // entry holds a block
	output logic [tag_width-1:0] tag_out // tag of the held block
);

	logic [num_blocks-1:0] valid_bits; // one per block and cleared on reset
	logic [tag_width-1:0] tags [num_blocks]; // guarded by valid_bits

	// valid bit set at the end of a fill
	always_ff @(posedge clk) begin
		if (reset)
			valid_bits <= '0;
		else if (write)
			valid_bits[index] <= 1'b1;
	end

	// tag store
	always_ff @(posedge clk) begin
		if (write)
			tags[index] <= tag_in;
	end

	// combinational lookup so the hit is decided in the request cycle
	assign valid = valid_bits[index];
	assign tag_out = tags[index];

endmodule

// ==== cache_sys.f ====
common/cache_pkg.sv
cache/cache_fill_fsm.sv
cache/cache_meta_array.sv
cache/cache_data_array.sv
cache/cache.sv
test/cache_assertions.sv
test/tb_cache.sv

// ==== common/cache_pkg.sv ====
package cache_pkg;

	// address and data word width
	localparam int addr_width = 16; // byte address, also the data word width

	// address split  tttt tiii iiii oooo
	localparam int tag_width = 5; // addr[15:11]
	localparam int index_width = 7; // addr[10:4]
	localparam int offset_width = 4; // addr[3:0], bit 0 unused for 16-bit words

	// word number inside a block
	localparam int word_sel_width = offset_width - 1; // addr[3:1]

	// array geometry
	localparam int num_blocks = 1 << index_width; // 128 direct-mapped entries
	localparam int words_per_block = 1 << word_sel_width; // 8 words per block

	// a miss fetches the whole block, one word per memory read
	localparam int fill_words = words_per_block;

	// fill controller states
	localparam logic [1:0] fsm_idle = 2'd0; // waiting for a miss
	localparam logic [1:0] fsm_fetch = 2'd1; // reading block words from memory
	localparam logic [1:0] fsm_finish = 2'd2; // tag write, one cycle

	// last word of a fill, compared against the word counter
	localparam logic [word_sel_width-1:0] last_fill_word = word_sel_width'(fill_words - 1);

endpackage

// ==== test/cache_assertions.sv ====
module cache_assertions (
	input logic clk,
	input logic reset,
	input logic cache_hit,
	input logic cache_miss,
	input logic cache_mem_read,
	input logic cache_mem_write,
	input logic cache_finish,
	input logic cache_busy
);

	// a request hits or misses, never both
	hit_or_miss: assert property (@(posedge clk) disable iff (reset)
		!(cache_hit && cache_miss))
		else $error("cache_hit and cache_miss high together");

	fill_read_busy: assert property (@(posedge clk) disable iff (reset)
		cache_mem_read |-> cache_busy)
		else $error("cache_mem_read outside a fill");

	finish_pulse: assert property (@(posedge clk) disable iff (reset)
		cache_finish |=> !cache_finish)
		else $error("cache_finish longer than one cycle");

	write_not_busy: assert property (@(posedge clk) disable iff (reset)
		cache_mem_write |-> !cache_busy) // fill owns the memory port
		else $error("cache_mem_write during a fill");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !cache_busy)
		else $error("cache_busy high out of reset");

	// busy only starts from a miss
	busy_from_miss: assert property (@(posedge clk) disable iff (reset)
		(!cache_busy && !cache_miss) |=> !cache_busy)
		else $error("cache_busy rose without cache_miss");

endmodule

bind cache cache_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.cache_hit(cache_hit),
	.cache_miss(cache_miss),
	.cache_mem_read(cache_mem_read),
	.cache_mem_write(cache_mem_write),
	.cache_finish(cache_finish),
	.cache_busy(cache_busy)
);

// ==== test/tb_cache.sv ====
module tb_cache import cache_pkg::*; ();

	localparam int num_requests = 600;
	localparam int max_request_cycles = 45; // miss, 8 words at 4+1 cycles, finish, hit
	localparam int timeout_cycles = ((num_requests * max_request_cycles + 9999) / 10000) * 10000;
	localparam int mem_words = 1 << (addr_width - 1); // word addressed with bit 0 dropped
	localparam int latency_bits = 13;
	localparam int latency_slots = 1 << latency_bits; // more than 600 fills of 8 words

	logic clk;
	logic reset;
	logic pipe_mem_read;
	logic [addr_width-1:0] pipe_read_addr;
	logic pipe_mem_write;
	logic [addr_width-1:0] pipe_write_addr;
	logic [addr_width-1:0] pipe_write_data;
	logic mem_data_valid;
	logic [addr_width-1:0] mem_read_data;
	logic cache_mem_read;
	logic cache_mem_write;
	logic [addr_width-1:0] cache_mem_addr;
	logic [addr_width-1:0] cache_data_out;
	logic cache_hit;
	logic cache_miss;
	logic cache_finish;
	logic cache_busy;

	logic [addr_width-1:0] mem [mem_words]; // memory model written by the stimulus only
	int latency [latency_slots]; // read latencies of 1 to 4 cycles drawn up front
	logic shadow_valid [num_blocks]; // expected valid bits
	logic [tag_width-1:0] shadow_tag [num_blocks]; // expected tags
	int miss_count; // predicted misses
	int finish_count; // observed cache_finish pulses

	cache uut (
		.clk(clk),
		.reset(reset),
		.pipe_mem_read(pipe_mem_read),
		.pipe_read_addr(pipe_read_addr),
		.pipe_mem_write(pipe_mem_write),
		.pipe_write_addr(pipe_write_addr),
		.pipe_write_data(pipe_write_data),
		.mem_data_valid(mem_data_valid),
		.mem_read_data(mem_read_data),
		.cache_mem_read(cache_mem_read),
		.cache_mem_write(cache_mem_write),
		.cache_mem_addr(cache_mem_addr),
		.cache_data_out(cache_data_out),
		.cache_hit(cache_hit),
		.cache_miss(cache_miss),
		.cache_finish(cache_finish),
		.cache_busy(cache_busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // period 20
	end

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	function automatic logic [addr_width-1:0] random_address();
		logic [tag_width-1:0] t;
		logic [index_width-1:0] i;
		logic [word_sel_width-1:0] w;
		t = tag_width'($urandom_range(3, 0)); // four tags fight over each index
		i = index_width'($urandom_range(15, 0)); // sixteen entries in use
		w = word_sel_width'($urandom);
		return {t, i, w, 1'b0};
	endfunction

	// write-through and read data in a cycle where the cache is not busy
	task automatic verify_access(input logic is_write, input logic [addr_width-1:0] a,
		input logic [addr_width-1:0] d);
		if (is_write) begin
			check_equal("cache_mem_write", 32'(cache_mem_write), 32'd1);
			check_equal("cache_mem_addr", 32'(cache_mem_addr), 32'(a));
			mem[a[addr_width-1:1]] = d; // memory takes it at the coming edge
		end else begin
			check_equal("cache_mem_write", 32'(cache_mem_write), 32'd0);
			if (cache_hit === 1'b1)
				check_equal("cache_data_out", 32'(cache_data_out), 32'(mem[a[addr_width-1:1]]));
		end
	endtask

	task automatic run_request(input logic is_write, input logic [addr_width-1:0] a,
		input logic [addr_width-1:0] d);
		logic [tag_width-1:0] t;
		logic [index_width-1:0] idx;
		logic [addr_width-1:0] base;
		logic predicted_hit;
		int words;
		t = a[addr_width-1 -: tag_width];
		idx = a[offset_width +: index_width];
		base = {a[addr_width-1:offset_width], {offset_width{1'b0}}};
		predicted_hit = shadow_valid[idx] && (shadow_tag[idx] == t);
		@(posedge clk);
		#2;
		pipe_mem_read = ~is_write;
		pipe_mem_write = is_write;
		pipe_read_addr = is_write ? ~a : a; // unused address gets a decoy
		pipe_write_addr = is_write ? a : ~a;
		pipe_write_data = d;
		@(negedge clk);
		check_equal("cache_hit", 32'(cache_hit), 32'(predicted_hit));
		check_equal("cache_miss", 32'(cache_miss), 32'(!predicted_hit));
		verify_access(is_write, a, d);
		if (!predicted_hit) begin
			miss_count++;
			words = 0;
			@(negedge clk);
			while (cache_finish !== 1'b1) begin
				check_equal("cache_busy", 32'(cache_busy), 32'd1);
				check_equal("cache_mem_write", 32'(cache_mem_write), 32'd0);
				if (mem_data_valid === 1'b1) begin // word taken at the next edge
					check_equal("cache_mem_addr", 32'(cache_mem_addr), 32'(base) + 32'(2 * words));
					words++;
				end
				@(negedge clk);
			end
			check_equal("fill words before cache_finish", 32'(words), 32'(fill_words));
			shadow_valid[idx] = 1'b1; // tag written with this edge
			shadow_tag[idx] = t;
			@(negedge clk);
			check_equal("cache_finish", 32'(cache_finish), 32'd0);
			check_equal("cache_hit", 32'(cache_hit), 32'd1); // held request after refill
			verify_access(is_write, a, d);
		end
	endtask

	// memory read port answering each read with a one-cycle valid
	initial begin : memory_read_port
		logic [addr_width-1:0] read_addr;
		logic [latency_bits-1:0] slot;
		int wait_cycles;
		mem_data_valid = 1'b0;
		mem_read_data = '0;
		slot = '0;
		forever begin
			@(negedge clk);
			if (cache_mem_read === 1'b1) begin
				read_addr = cache_mem_addr;
				wait_cycles = latency[slot];
				slot = slot + 1'b1;
				repeat (wait_cycles - 1) begin
					@(negedge clk);
					check_equal("cache_mem_read", 32'(cache_mem_read), 32'd1); // held until valid
					check_equal("cache_mem_addr", 32'(cache_mem_addr), 32'(read_addr));
				end
				@(posedge clk);
				#2;
				mem_data_valid = 1'b1;
				mem_read_data = mem[read_addr[addr_width-1:1]];
				@(posedge clk);
				#2;
				mem_data_valid = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (cache_finish === 1'b1)
			finish_count++;
	end

	initial begin : watchdog
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: no end of test after %0d cycles, the run hung", cycle_count);
		$display("Something failed");
		$fatal(1);
	end

	initial begin : stimulus
		logic is_write;
		logic [addr_width-1:0] a;
		logic [addr_width-1:0] d;
		void'($urandom(32'h7de7_ad88));
		reset = 1'b1;
		pipe_mem_read = 1'b0;
		pipe_read_addr = '0;
		pipe_mem_write = 1'b0;
		pipe_write_addr = '0;
		pipe_write_data = '0;
		miss_count = 0;
		shadow_valid = '{default: 1'b0};
		for (int i = 0; i < mem_words; i++)
			mem[i[addr_width-2:0]] = 16'($urandom);
		for (int i = 0; i < latency_slots; i++)
			latency[i[latency_bits-1:0]] = int'($urandom_range(4, 1));
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int n = 0; n < num_requests; n++) begin
			is_write = ($urandom_range(99, 0) < 30); // 30% writes
			a = random_address();
			d = 16'($urandom);
			run_request(is_write, a, d);
		end
		check_equal("cache_finish pulses", 32'(finish_count), 32'(miss_count));
		$display("Everything OK");
		$finish;
	end

endmodule
